// ==== verilog/fixpu_pkg.sv ====
`default_nettype none

package fixpu_pkg;

  // data widths
  typedef logic [31:0] word_t;  // operand word
  typedef logic [32:0] sum_t;   // carry over a 32-bit sum
  typedef logic [63:0] wide_t;  // product and top-level result
  typedef logic [5:0]  cnt_t;   // latency counter, reaches DIV_LATENCY

  // operation codes as seen on mode
  typedef enum logic [1:0] {
    OP_ADD,
    OP_SUB,
    OP_MUL,
    OP_DIV
  } op_t;

  // operand pair latched at start and shared by all units
  typedef struct packed {
    word_t a;  // left operand, dividend
    word_t b;  // right operand, divisor
  } operands_t;

  // counted cycles before the sequencer takes a unit's result
  localparam cnt_t ADD_LATENCY = 6'd3;   // adder depth is 2
  localparam cnt_t MUL_LATENCY = 6'd8;   // multiplier depth is 4
  localparam cnt_t DIV_LATENCY = 6'd40;  // divider depth is 32

endpackage

`default_nettype wire

// ==== verilog/fix_add.sv ====
`timescale 1ns/1ps
`default_nettype none

module fix_add (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 en,      // advances both stages
  input  logic                 sub,     // negate b before the sum
  input  fixpu_pkg::operands_t ops,
  output fixpu_pkg::sum_t      result
);
  import fixpu_pkg::*;

  operands_t s1;  // stage one, b already negated for subtract

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      s1 <= '0;
    end else if (en) begin
      s1.a <= ops.a;
      s1.b <= sub ? ~ops.b + 1'b1 : ops.b;  // two's complement of b
    end
  end

  // stage two, carry lands in the top bit
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      result <= '0;
    end else if (en) begin
      result <= {1'b0, s1.a} + {1'b0, s1.b};
    end
  end

  // the whole pipeline freezes while the enable is low
  a_hold_when_idle : assert property (
    @(posedge clk) disable iff (rst)
    !en |=> $stable(result)
  ) else $error("fix_add result moved while en was low");

endmodule

`default_nettype wire

// ==== verilog/fix_mul.sv ====
`timescale 1ns/1ps
`default_nettype none

module fix_mul (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 en,      // stalls all four stages
  input  fixpu_pkg::operands_t ops,
  output fixpu_pkg::wide_t     result
);
  import fixpu_pkg::*;

  // 16x16 partial products, named by the operand halves used
  typedef struct packed {
    logic [31:0] hh;
    logic [31:0] hl;
    logic [31:0] lh;
    logic [31:0] ll;
  } pprod_t;

  operands_t   s1;     // registered operands
  pprod_t      s2;     // four partial products
  logic [32:0] s3_mid; // lh + hl, weight 2^16
  logic [31:0] s3_hh;  // weight 2^32
  logic [31:0] s3_ll;  // weight 1

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      s1     <= '0;
      s2     <= '0;
      s3_mid <= '0;
      s3_hh  <= '0;
      s3_ll  <= '0;
      result <= '0;
    end else if (en) begin
      s1 <= ops;

      s2.hh <= s1.a[31:16] * s1.b[31:16];
      s2.hl <= s1.a[31:16] * s1.b[15:0];
      s2.lh <= s1.a[15:0] * s1.b[31:16];
      s2.ll <= s1.a[15:0] * s1.b[15:0];

      s3_mid <= {1'b0, s2.lh} + {1'b0, s2.hl};  // middle terms share a weight
      s3_hh  <= s2.hh;
      s3_ll  <= s2.ll;

      // outer products sit side by side, middle sum shifted in
      result <= {s3_hh, s3_ll} + {15'd0, s3_mid, 16'd0};
    end
  end

endmodule

`default_nettype wire

// ==== verilog/fix_div.sv ====
`timescale 1ns/1ps
`default_nettype none

module fix_div (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 en,      // stalls every stage
  input  fixpu_pkg::operands_t ops,
  output fixpu_pkg::word_t     result
);
  import fixpu_pkg::*;

  localparam int STAGES = 32;  // one quotient bit per stage

  // state carried from stage to stage
  typedef struct packed {
    word_t rem;  // partial remainder
    word_t nq;   // dividend bits shift out at the top, quotient bits in at the bottom
    word_t den;  // divisor
  } div_stage_t;

  div_stage_t pipe [0:STAGES-1];  // registered output of each stage

  for (genvar i = 0; i < STAGES; i++) begin : g_stage
    div_stage_t  cur;    // stage input
    div_stage_t  nxt;    // stage result before the register
    logic [32:0] trial;  // remainder with next dividend bit appended
    logic [32:0] diff;
    logic        fits;   // divisor goes into trial

    if (i == 0) begin : g_head
      assign cur = '{rem: '0, nq: ops.a, den: ops.b};
    end else begin : g_link
      assign cur = pipe[i-1];
    end

    assign trial = {cur.rem, cur.nq[31]};
    assign diff  = trial - {1'b0, cur.den};
    assign fits  = trial >= {1'b0, cur.den};  // always true for a zero divisor

    // restore by keeping trial when the subtract would go negative
    assign nxt = '{
      rem: fits ? diff[31:0] : trial[31:0],
      nq:  {cur.nq[30:0], fits},
      den: cur.den
    };

    always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
        pipe[i] <= '0;
      end else if (en) begin
        pipe[i] <= nxt;
      end
    end
  end

  // all dividend bits have been consumed by the last stage
  assign result = pipe[STAGES-1].nq;

endmodule

`default_nettype wire

// ==== verilog/fixpu_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

module fixpu_seq (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 en,       // qualifies start only
  input  logic                 start,
  input  fixpu_pkg::op_t       mode,
  input  fixpu_pkg::word_t     a,
  input  fixpu_pkg::word_t     b,
  output fixpu_pkg::operands_t ops,      // latched operands to the units
  output logic                 sub,      // subtract select for fix_add
  output logic                 add_en,
  output logic                 mul_en,
  output logic                 div_en,
  input  fixpu_pkg::sum_t      add_res,
  input  fixpu_pkg::wide_t     mul_res,
  input  fixpu_pkg::word_t     div_res,
  output logic                 done,     // one-cycle pulse
  output fixpu_pkg::wide_t     result    // held until the next done
);
  import fixpu_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_ADD,
    S_MUL,
    S_DIV
  } seq_state_t;

  seq_state_t state;
  op_t        op_q;       // latched operation code
  cnt_t       cnt;        // edges counted since acceptance
  cnt_t       budget;     // latency of the running operation
  logic       accept;
  logic       run;        // chosen unit still enabled
  logic       capture;    // last enabled edge, take unit output
  logic       finish;
  wide_t      unit_res;   // selected unit output, widened
  wide_t      stage_res;  // staging register ahead of result

  assign accept = (state == S_IDLE) && start && en;

  always_comb begin
    case (state)
      S_ADD:   budget = ADD_LATENCY;
      S_MUL:   budget = MUL_LATENCY;
      S_DIV:   budget = DIV_LATENCY;
      default: budget = '0;
    endcase
  end

  assign run     = (state != S_IDLE) && (cnt < budget);
  assign capture = run && (cnt == budget - 1'b1);
  assign finish  = (state != S_IDLE) && (cnt == budget);

  assign add_en = run && (state == S_ADD);
  assign mul_en = run && (state == S_MUL);
  assign div_en = run && (state == S_DIV);
  assign sub    = (op_q == OP_SUB);

  always_comb begin
    case (state)
      S_MUL:   unit_res = mul_res;
      S_DIV:   unit_res = {32'd0, div_res};
      default: unit_res = {31'd0, add_res};  // carry kept in bit 32
    endcase
  end

  // payload, loaded without reset
  always_ff @(posedge clk) begin
    if (accept) begin
      ops.a <= a;
      ops.b <= b;
    end
    if (capture) begin
      stage_res <= unit_res;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state  <= S_IDLE;
      op_q   <= OP_ADD;
      cnt    <= '0;
      done   <= 1'b0;
      result <= '0;
    end else begin
      done <= 1'b0;
      if (accept) begin
        op_q <= mode;
        cnt  <= '0;
        case (mode)
          OP_MUL:  state <= S_MUL;
          OP_DIV:  state <= S_DIV;
          default: state <= S_ADD;  // add and subtract share the adder
        endcase
      end else if (finish) begin
        state  <= S_IDLE;
        done   <= 1'b1;
        result <= stage_res;
      end else if (state != S_IDLE) begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  // only one unit may advance at a time
  a_en_onehot : assert property (
    @(posedge clk) disable iff (rst)
    $onehot0({add_en, mul_en, div_en})
  ) else $error("more than one unit enable high");

  a_done_pulse : assert property (
    @(posedge clk) disable iff (rst)
    done |=> !done
  ) else $error("done held high for two cycles");

endmodule

`default_nettype wire

// ==== verilog/fixpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module fixpu (
  input  logic             clk,
  input  logic             rst,
  input  logic             en,
  input  logic             start,
  input  fixpu_pkg::op_t   mode,
  input  fixpu_pkg::word_t a,
  input  fixpu_pkg::word_t b,
  output logic             done,
  output fixpu_pkg::wide_t result
);
  import fixpu_pkg::*;

  operands_t ops;      // latched operands, shared by all units
  logic      sub;
  logic      add_en;
  logic      mul_en;
  logic      div_en;
  sum_t      add_res;
  wide_t     mul_res;
  word_t     div_res;

  fixpu_seq i_seq (
    .clk     (clk),
    .rst     (rst),
    .en      (en),
    .start   (start),
    .mode    (mode),
    .a       (a),
    .b       (b),
    .ops     (ops),
    .sub     (sub),
    .add_en  (add_en),
    .mul_en  (mul_en),
    .div_en  (div_en),
    .add_res (add_res),
    .mul_res (mul_res),
    .div_res (div_res),
    .done    (done),
    .result  (result)
  );

  fix_add i_add (
    .clk    (clk),
    .rst    (rst),
    .en     (add_en),
    .sub    (sub),
    .ops    (ops),
    .result (add_res)
  );

  fix_mul i_mul (
    .clk    (clk),
    .rst    (rst),
    .en     (mul_en),
    .ops    (ops),
    .result (mul_res)
  );

  fix_div i_div (
    .clk    (clk),
    .rst    (rst),
    .en     (div_en),
    .ops    (ops),
    .result (div_res)
  );

endmodule

`default_nettype wire

// ==== bench/tb_fixpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fixpu;
  import fixpu_pkg::*;

  localparam int DONE_TIMEOUT = 64;  // cycles allowed per operation
  localparam int RANDOM_OPS   = 190;

  logic  clk;
  logic  rst;
  logic  en;
  logic  start;
  op_t   mode;
  word_t a;
  word_t b;
  logic  done;
  wide_t result;

  logic [15:0] lfsr_state;  // stimulus source
  wide_t       exp_result;  // recorded when start is driven
  int          exp_edges;   // edges from acceptance to done rising
  logic        model_busy;
  int          edge_cnt;    // edges seen since acceptance
  logic        exp_done;
  logic        completed;   // at least one operation has finished

  fixpu i_fixpu (
    .clk    (clk),
    .rst    (rst),
    .en     (en),
    .start  (start),
    .mode   (mode),
    .a      (a),
    .b      (b),
    .done   (done),
    .result (result)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic value_error(input string name, input wide_t got, input wide_t want);
    abort_run($sformatf("ERR %s: got %h expected %h", name, got, want));
  endtask

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];  // x^16 + x^14 + x^13 + x^11 + 1
    return {s[14:0], fb};
  endfunction

  // one LFSR step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // expected result from the operation rules
  function automatic wide_t expect_result(input op_t m, input word_t x, input word_t y);
    logic [32:0] s;
    word_t       neg;
    neg = ~y + 32'd1;
    case (m)
      OP_ADD: s = {1'b0, x} + {1'b0, y};
      OP_SUB: s = {1'b0, x} + {1'b0, neg};
      default: s = '0;
    endcase
    case (m)
      OP_MUL:  return {32'd0, x} * {32'd0, y};
      OP_DIV:  return (y == 32'd0) ? 64'h0000_0000_ffff_ffff : {32'd0, x / y};
      default: return {31'd0, s};
    endcase
  endfunction

  function automatic int done_edges(input op_t m);
    case (m)
      OP_MUL:  return 9;
      OP_DIV:  return 41;
      default: return 4;  // add and subtract
    endcase
  endfunction

  // reference timing of acceptance and the done pulse
  always @(posedge clk or posedge rst) begin
    if (rst) begin
      model_busy <= 1'b0;
      edge_cnt   <= 0;
      exp_done   <= 1'b0;
      completed  <= 1'b0;
    end else begin
      exp_done <= 1'b0;
      if (!model_busy) begin
        if (start && en) begin
          model_busy <= 1'b1;
          edge_cnt   <= 1;
        end
      end else if (edge_cnt == exp_edges) begin
        model_busy <= 1'b0;
        exp_done   <= 1'b1;
        completed  <= 1'b1;
      end else begin
        edge_cnt <= edge_cnt + 1;
      end
    end
  end

  a_done_timing : assert property (
    @(posedge clk) disable iff (rst)
    done == exp_done
  ) else abort_run("done pulse came at the wrong edge or lasted more than one cycle");

  a_result_value : assert property (
    @(posedge clk) disable iff (rst)
    done |-> result == exp_result
  ) else value_error("result", $sampled(result), exp_result);

  a_result_hold : assert property (
    @(posedge clk) disable iff (rst)
    !done |-> $stable(result)
  ) else value_error("result", $sampled(result), $past(result));

  a_reset_clear : assert property (
    @(posedge clk) disable iff (rst)
    !completed |-> result == '0
  ) else value_error("result", $sampled(result), '0);

  task automatic wait_done();
    int n;
    n = 0;
    while (!done && n < DONE_TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (!done) begin
      abort_run("done never arrived within the timeout");
    end
  endtask

  // poke adds a start with en low before, and a start while busy after
  task automatic run_op(input op_t m, input word_t x, input word_t y, input logic poke);
    if (poke) begin
      @(posedge clk);
      start <= 1'b1;
      en    <= 1'b0;
      mode  <= m;
      a     <= ~x;
      b     <= ~y;
      @(posedge clk);
      start <= 1'b0;
    end
    @(posedge clk);
    start      <= 1'b1;
    en         <= 1'b1;
    mode       <= m;
    a          <= x;
    b          <= y;
    exp_result <= expect_result(m, x, y);
    exp_edges  <= done_edges(m);
    @(posedge clk);  // accepting edge
    start <= 1'b0;
    en    <= 1'(take_bits(1));  // en is ignored once busy
    a     <= take_bits(32); // operands already latched
    b     <= take_bits(32);
    mode  <= op_t'(take_bits(2));
    if (poke) begin
      @(posedge clk);
      start <= 1'b1;
      en    <= 1'b1;
      @(posedge clk);  // seen while busy
      start <= 1'b0;
    end
    wait_done();
  endtask

  initial begin
    op_t   m;
    word_t x;
    word_t y;
    logic [1:0] sel;
    rst        = 1'b1;
    en         = 1'b0;
    start      = 1'b0;
    mode       = OP_ADD;
    a          = '0;
    b          = '0;
    lfsr_state = 16'd25163;
    exp_result = '0;
    exp_edges  = 4;

    repeat (5) @(posedge clk);
    rst <= 1'b0;
    repeat (3) @(posedge clk);

    // corner values
    run_op(OP_ADD, 32'h0, 32'h0, 1'b0);
    run_op(OP_ADD, 32'hffff_ffff, 32'hffff_ffff, 1'b1);
    run_op(OP_SUB, 32'h0, 32'h0, 1'b0);
    run_op(OP_SUB, 32'h5, 32'h9, 1'b1);  // borrow, carry clear
    run_op(OP_SUB, 32'hffff_ffff, 32'h0, 1'b0);
    run_op(OP_MUL, 32'hffff_ffff, 32'hffff_ffff, 1'b0);
    run_op(OP_MUL, 32'h0, 32'h1234_5678, 1'b1);
    run_op(OP_DIV, 32'hdead_beef, 32'h0, 1'b0);
    run_op(OP_DIV, 32'h3, 32'h7, 1'b1);
    run_op(OP_DIV, 32'hffff_ffff, 32'h1, 1'b0);
    run_op(OP_DIV, 32'h0, 32'h0, 1'b0);

    for (int i = 0; i < RANDOM_OPS; i++) begin
      m   = op_t'(take_bits(2));
      sel = 2'(take_bits(2));
      x   = take_bits(32);
      y   = take_bits(32);
      case (sel)
        2'd0: y = take_bits(8);   // small divisor, zero now and then
        2'd1: x = take_bits(16);  // a below b most of the time
        default: ;
      endcase
      run_op(m, x, y, take_bits(3) == '0);
    end

    repeat (4) @(posedge clk);
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
verilog/fixpu_pkg.sv
verilog/fix_add.sv
verilog/fix_mul.sv
verilog/fix_div.sv
verilog/fixpu_seq.sv
verilog/fixpu.sv
bench/tb_fixpu.sv

// ==== Bender.yml ====
package:
  name: fixpu

sources:
  - verilog/fixpu_pkg.sv
  - verilog/fix_add.sv
  - verilog/fix_mul.sv
  - verilog/fix_div.sv
  - verilog/fixpu_seq.sv
  - verilog/fixpu.sv
  - target: simulation
    files:
      - bench/tb_fixpu.sv
